// ==== verilog/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

    // Cache geometry, all in bytes unless named as a width
    localparam int ADDR_WIDTH     = 32;
    localparam int INSN_WIDTH     = 32;
    localparam int CACHE_SIZE     = 1024;
    localparam int LINE_SIZE      = 32;

    // Derived sizes
    localparam int LINE_WIDTH     = LINE_SIZE * 8;
    localparam int WORDS_PER_LINE = LINE_WIDTH / INSN_WIDTH;
    localparam int LINE_COUNT     = CACHE_SIZE / LINE_SIZE;

    // Address field widths
    localparam int BYTE_BITS      = $clog2(INSN_WIDTH / 8);
    localparam int WORD_BITS      = $clog2(WORDS_PER_LINE);
    localparam int OFFSET_WIDTH   = BYTE_BITS + WORD_BITS;
    localparam int INDEX_WIDTH    = $clog2(LINE_COUNT);
    localparam int TAG_WIDTH      = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

    // Fetch address split into its cache fields, MSB first
    typedef struct packed {
        logic [TAG_WIDTH-1:0]   tag;
        logic [INDEX_WIDTH-1:0] index;
        logic [WORD_BITS-1:0]   word;
        logic [BYTE_BITS-1:0]   byte_sel;
    } ic_addr_t;

    // One line as held in the array
    typedef struct packed {
        logic                   valid;
        logic [TAG_WIDTH-1:0]   tag;
        logic [LINE_WIDTH-1:0]  data;
    } ic_entry_t;

    // Array write payload from the refill unit
    typedef struct packed {
        logic [INDEX_WIDTH-1:0] index;
        logic [TAG_WIDTH-1:0]   tag;
        logic [LINE_WIDTH-1:0]  data;
    } ic_fill_t;

    // Refill FSM states
    typedef enum logic {
        REFILL_IDLE = 1'b0,
        REFILL_WAIT = 1'b1
    } refill_state_t;

endpackage

`default_nettype wire

// ==== verilog/icache_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_array (
    input  logic                                 clk,
    input  logic                                 i_reset,

    // Read port, entry comes back one cycle later
    input  logic                                 i_rd_en,
    input  logic [icache_pkg::INDEX_WIDTH-1:0]   i_rd_index,
    output icache_pkg::ic_entry_t                o_rd_entry,

    // Write port from the refill unit
    input  logic                                 i_wr_en,
    input  icache_pkg::ic_fill_t                 i_wr_fill
);

    // Valid bits live in flops so reset can clear them all at once
    logic [icache_pkg::LINE_COUNT-1:0] valid_r;

    // Tag and data storage
    logic [icache_pkg::TAG_WIDTH-1:0]  tag_mem  [icache_pkg::LINE_COUNT];
    logic [icache_pkg::LINE_WIDTH-1:0] data_mem [icache_pkg::LINE_COUNT];

    // Valid state
    always_ff @(posedge clk) begin
        if (i_reset) begin
            valid_r <= '0;
        end else if (i_wr_en) begin
            valid_r[i_wr_fill.index] <= 1'b1;
        end
    end

    // A fill always writes the whole line
    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            tag_mem[i_wr_fill.index]  <= i_wr_fill.tag;
            data_mem[i_wr_fill.index] <= i_wr_fill.data;
        end
    end

    // Synchronous read
    // A write to the same index at this edge is not seen until the next read
    always_ff @(posedge clk) begin
        if (i_rd_en) begin
            o_rd_entry.valid <= valid_r[i_rd_index];
            o_rd_entry.tag   <= tag_mem[i_rd_index];
            o_rd_entry.data  <= data_mem[i_rd_index];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/icache.sv ====
`timescale 1ns/1ps
`default_nettype none

// Two-stage instruction cache lookup
// IT stage reads the array, IR stage forms the hit and picks the word

module icache (
    input  logic                                 clk,
    input  logic                                 i_reset,

    // Lookup request and result
    input  logic                                 i_ic_en,
    input  icache_pkg::ic_addr_t                 i_ic_addr,
    output logic                                 o_ic_hit,
    output logic                                 o_ic_miss,
    output icache_pkg::ic_addr_t                 o_ic_miss_addr,
    output logic [icache_pkg::INSN_WIDTH-1:0]    o_ic_data,

    // Array read port
    output logic                                 o_rd_en,
    output logic [icache_pkg::INDEX_WIDTH-1:0]   o_rd_index,
    input  icache_pkg::ic_entry_t                i_rd_entry
);

    // IT stage
    // The index goes straight to the array, the entry returns next cycle
    assign o_rd_en    = i_ic_en;
    assign o_rd_index = i_ic_addr.index;

    // IT -> IR pipeline registers
    logic                 it_en_r;
    icache_pkg::ic_addr_t it_addr_r;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            it_en_r <= 1'b0;
        end else begin
            it_en_r <= i_ic_en;
        end
    end

    // Tag and word select ride along with the full address
    always_ff @(posedge clk) begin
        it_addr_r <= i_ic_addr;
    end

    // IR stage
    logic                              tag_match;
    logic                              ic_hit;
    logic                              ic_miss;
    logic [icache_pkg::INSN_WIDTH-1:0] insn_data;

    assign tag_match = i_rd_entry.valid && (i_rd_entry.tag == it_addr_r.tag);

    // Only a real lookup reports anything
    assign ic_hit  = it_en_r && tag_match;
    assign ic_miss = it_en_r && !tag_match;

    // Instructions are word aligned within the line
    assign insn_data = i_rd_entry.data[it_addr_r.word * icache_pkg::INSN_WIDTH +:
                                       icache_pkg::INSN_WIDTH];

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_ic_hit  <= 1'b0;
            o_ic_miss <= 1'b0;
        end else begin
            o_ic_hit  <= ic_hit;
            o_ic_miss <= ic_miss;
        end
    end

    // Data and miss address are payload, qualified by hit and miss
    always_ff @(posedge clk) begin
        o_ic_data      <= insn_data;
        o_ic_miss_addr <= it_addr_r;
    end

endmodule

`default_nettype wire

// ==== verilog/icache_refill.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_refill (
    input  logic                                 clk,
    input  logic                                 i_reset,

    // Miss from the lookup pipeline
    input  logic                                 i_miss,
    input  icache_pkg::ic_addr_t                 i_miss_addr,

    // Memory port, one response per request
    output logic                                 o_mem_req,
    output logic [icache_pkg::ADDR_WIDTH-1:0]    o_mem_addr,
    input  logic                                 i_mem_valid,
    input  logic [icache_pkg::LINE_WIDTH-1:0]    i_mem_data,

    // Array write
    output logic                                 o_fill_en,
    output icache_pkg::ic_fill_t                 o_fill
);

    icache_pkg::refill_state_t state_r;
    icache_pkg::ic_addr_t      line_addr_r;
    logic                      miss_accept;

    // Misses while a refill is outstanding are dropped
    assign miss_accept = (state_r == icache_pkg::REFILL_IDLE) && i_miss;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state_r   <= icache_pkg::REFILL_IDLE;
            o_mem_req <= 1'b0;
        end else begin
            o_mem_req <= 1'b0;
            case (state_r)
                icache_pkg::REFILL_IDLE: begin
                    if (i_miss) begin
                        state_r   <= icache_pkg::REFILL_WAIT;
                        o_mem_req <= 1'b1;
                    end
                end
                icache_pkg::REFILL_WAIT: begin
                    if (i_mem_valid) begin
                        state_r <= icache_pkg::REFILL_IDLE;
                    end
                end
                default: begin
                    state_r <= icache_pkg::REFILL_IDLE;
                end
            endcase
        end
    end

    // Line-aligned address, held until the response arrives
    always_ff @(posedge clk) begin
        if (miss_accept) begin
            line_addr_r.tag      <= i_miss_addr.tag;
            line_addr_r.index    <= i_miss_addr.index;
            line_addr_r.word     <= '0;
            line_addr_r.byte_sel <= '0;
        end
    end

    assign o_mem_addr = line_addr_r;

    // The response becomes one array write in the same cycle
    assign o_fill_en    = (state_r == icache_pkg::REFILL_WAIT) && i_mem_valid;
    assign o_fill.index = line_addr_r.index;
    assign o_fill.tag   = line_addr_r.tag;
    assign o_fill.data  = i_mem_data;

endmodule

`default_nettype wire

// ==== verilog/icache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_top (
    input  logic                                 clk,
    input  logic                                 i_reset,

    // Fetch port
    input  logic                                 i_fetch_en,
    input  logic [icache_pkg::ADDR_WIDTH-1:0]    i_fetch_addr,
    output logic                                 o_fetch_hit,
    output logic                                 o_fetch_miss,
    output logic [icache_pkg::INSN_WIDTH-1:0]    o_fetch_data,

    // Memory port
    output logic                                 o_mem_req,
    output logic [icache_pkg::ADDR_WIDTH-1:0]    o_mem_addr,
    input  logic                                 i_mem_valid,
    input  logic [icache_pkg::LINE_WIDTH-1:0]    i_mem_data
);

    // Array read path
    logic                               rd_en;
    logic [icache_pkg::INDEX_WIDTH-1:0] rd_index;
    icache_pkg::ic_entry_t              rd_entry;

    // Miss and fill path
    logic                               ic_miss;
    icache_pkg::ic_addr_t               ic_miss_addr;
    logic                               fill_en;
    icache_pkg::ic_fill_t               fill;

    icache icache_inst (
        .clk            (clk),
        .i_reset        (i_reset),
        .i_ic_en        (i_fetch_en),
        .i_ic_addr      (icache_pkg::ic_addr_t'(i_fetch_addr)),
        .o_ic_hit       (o_fetch_hit),
        .o_ic_miss      (ic_miss),
        .o_ic_miss_addr (ic_miss_addr),
        .o_ic_data      (o_fetch_data),
        .o_rd_en        (rd_en),
        .o_rd_index     (rd_index),
        .i_rd_entry     (rd_entry)
    );

    assign o_fetch_miss = ic_miss;

    icache_array icache_array_inst (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_rd_en    (rd_en),
        .i_rd_index (rd_index),
        .o_rd_entry (rd_entry),
        .i_wr_en    (fill_en),
        .i_wr_fill  (fill)
    );

    icache_refill icache_refill_inst (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_miss      (ic_miss),
        .i_miss_addr (ic_miss_addr),
        .o_mem_req   (o_mem_req),
        .o_mem_addr  (o_mem_addr),
        .i_mem_valid (i_mem_valid),
        .i_mem_data  (i_mem_data),
        .o_fill_en   (fill_en),
        .o_fill      (fill)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

// Free-running clock, 20 ns period
module tb_clock (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
    end

    always #10 o_clk = ~o_clk;

endmodule

`default_nettype wire

// ==== testbench/tb_icache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_icache;

    localparam int          SEED         = 97;
    localparam int          RAND_LOOKUPS = 500;
    localparam int          HIT_TRIES    = 40;
    localparam time         WATCHDOG_NS  = 600 * 12 * 20;
    localparam logic [31:0] DATA_MASK    = 32'h5A5A_0000;

    logic         clk;
    logic         rst;
    logic         fetch_en;
    logic [31:0]  fetch_addr;
    logic         fetch_hit;
    logic         fetch_miss;
    logic [31:0]  fetch_data;
    logic         mem_req;
    logic [31:0]  mem_addr;
    logic         mem_valid;
    logic [255:0] mem_data;

    // Reference model of the array and refill FSM
    logic [31:0] valid_m;
    logic [21:0] tag_m [32];
    logic        busy_m;
    logic        req_exp;
    logic [31:0] req_line;
    logic        st1_en, st1_hit, st2_en, st2_hit;
    logic [31:0] st1_addr, st2_addr;

    // Memory model state
    logic        mem_busy;
    logic [31:0] mem_line;
    int          mem_wait;

    int errors;
    int checks;
    int hits;
    int reqs;

    tb_clock clock_gen (
        .o_clk (clk)
    );

    icache_top i_dut (
        .clk          (clk),
        .i_reset      (rst),
        .i_fetch_en   (fetch_en),
        .i_fetch_addr (fetch_addr),
        .o_fetch_hit  (fetch_hit),
        .o_fetch_miss (fetch_miss),
        .o_fetch_data (fetch_data),
        .o_mem_req    (mem_req),
        .o_mem_addr   (mem_addr),
        .i_mem_valid  (mem_valid),
        .i_mem_data   (mem_data)
    );

    // Word at byte address A is A xor the data mask
    function automatic logic [31:0] model_word(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ DATA_MASK;
    endfunction

    function automatic logic [255:0] model_line(input logic [31:0] line);
        logic [255:0] d;
        for (int w = 0; w < 8; w++) begin
            d[w*32 +: 32] = model_word({line[31:5], 5'b0} + 32'(w * 4));
        end
        return d;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
    endtask

    // What each clock edge does to the cache
    always @(posedge clk) begin
        logic miss_now;
        logic new_hit;
        if (rst) begin
            valid_m = '0;
            busy_m  = 1'b0;
            req_exp = 1'b0;
            st1_en  = 1'b0;
            st2_en  = 1'b0;
        end else begin
            miss_now = st2_en && !st2_hit;
            req_exp  = 1'b0;
            // Lookup sees the array as it was before this edge
            new_hit  = fetch_en && valid_m[fetch_addr[9:5]] &&
                       (tag_m[fetch_addr[9:5]] == fetch_addr[31:10]);
            if (busy_m && mem_valid) begin
                valid_m[req_line[9:5]] = 1'b1;
                tag_m[req_line[9:5]]   = req_line[31:10];
                busy_m                 = 1'b0;
            end else if (!busy_m && miss_now) begin
                busy_m   = 1'b1;
                req_exp  = 1'b1;
                req_line = {st2_addr[31:5], 5'b0};
            end
            st2_en   = st1_en;
            st2_hit  = st1_hit;
            st2_addr = st1_addr;
            st1_en   = fetch_en;
            st1_hit  = new_hit;
            st1_addr = fetch_addr;
        end
    end

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            checks++;
            assert (fetch_hit === (st2_en && st2_hit))
                else report_mismatch("o_fetch_hit", 32'(fetch_hit), 32'(st2_en && st2_hit));
            assert (fetch_miss === (st2_en && !st2_hit))
                else report_mismatch("o_fetch_miss", 32'(fetch_miss), 32'(st2_en && !st2_hit));
            if (st2_en && st2_hit) begin
                hits++;
                assert (fetch_data === model_word(st2_addr))
                    else report_mismatch("o_fetch_data", fetch_data, model_word(st2_addr));
            end
            assert (mem_req === req_exp)
                else report_mismatch("o_mem_req", 32'(mem_req), 32'(req_exp));
            if (req_exp) begin
                reqs++;
            end
            // Line address holds from the request until the response
            if (busy_m) begin
                assert (mem_addr === req_line)
                    else report_mismatch("o_mem_addr", mem_addr, req_line);
            end
        end
    end

    // Memory answers each request after 1 to 8 cycles
    always @(negedge clk) begin
        mem_valid = 1'b0;
        if (rst) begin
            mem_busy = 1'b0;
        end else if (mem_busy) begin
            if (mem_wait == 0) begin
                mem_valid = 1'b1;
                mem_data  = model_line(mem_line);
                mem_busy  = 1'b0;
            end else begin
                mem_wait--;
            end
        end else if (mem_req) begin
            mem_busy = 1'b1;
            mem_line = mem_addr;
            mem_wait = $urandom_range(0, 7);
        end
    end

    // Called at a falling edge, returns after the given idle cycles
    task automatic lookup(input logic [31:0] addr, input int gap);
        fetch_en   = 1'b1;
        fetch_addr = addr;
        @(negedge clk);
        fetch_en = 1'b0;
        repeat (gap) @(negedge clk);
    endtask

    task automatic fetch_until_hit(input logic [31:0] addr);
        bit done;
        done = 0;
        for (int t = 0; t < HIT_TRIES && !done; t++) begin
            lookup(addr, 1);
            if (fetch_hit) begin
                done = 1;
            end else begin
                repeat (2) @(negedge clk);
            end
        end
        if (!done) begin
            errors++;
            $display("Address %h never hit after %0d refetches", addr, HIT_TRIES);
        end
    endtask

    task automatic wait_refill_idle();
        int n;
        n = 0;
        while ((busy_m || mem_busy) && n < 50) begin
            @(negedge clk);
            n++;
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        void'($urandom(SEED));
        errors     = 0;
        checks     = 0;
        hits       = 0;
        reqs       = 0;
        rst        = 1'b1;
        fetch_en   = 1'b0;
        fetch_addr = '0;
        mem_valid  = 1'b0;
        mem_data   = '0;
        mem_busy   = 1'b0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        repeat (5) @(negedge clk);

        // First lookup misses, then refill and hit
        a = 32'h0000_1040;
        fetch_until_hit(a);
        // All words of the line, strobed back to back
        for (int w = 0; w < 8; w++) begin
            lookup({a[31:5], 5'b0} + 32'(w * 4), 0);
        end
        repeat (3) @(negedge clk);

        // Same index with another tag evicts the first line
        b = a + 32'd1024;
        fetch_until_hit(b);
        lookup(a, 1);
        if (fetch_hit) begin
            errors++;
            $display("Evicted address %h still hit", a);
        end
        fetch_until_hit(a);

        // Random lookups over 4 tags, 4 indexes and all words
        for (int i = 0; i < RAND_LOOKUPS; i++) begin
            r = 32'($urandom_range(0, 3)) * 1024 + 32'($urandom_range(0, 3)) * 32
                + 32'($urandom_range(0, 7)) * 4 + 32'h0000_4000;
            lookup(r, $urandom_range(0, 2));
        end

        // Reset in mid-run clears every line
        repeat (3) @(negedge clk);
        // The random set shares this index, so bring the line back first
        fetch_until_hit(a);
        wait_refill_idle();
        rst = 1'b1;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        lookup(a, 1);
        if (fetch_hit) begin
            errors++;
            $display("Address %h hit after reset", a);
        end
        fetch_until_hit(a);
        repeat (12) @(negedge clk);

        if (hits == 0 || reqs == 0) begin
            errors++;
            $display("Stimulus produced no hits or no memory requests");
        end
        $display("checks=%0d hits=%0d requests=%0d errors=%0d", checks, hits, reqs, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
verilog/icache_pkg.sv
verilog/icache_array.sv
verilog/icache.sv
verilog/icache_refill.sv
verilog/icache_top.sv
testbench/tb_clock.sv
testbench/tb_icache.sv

// ==== Makefile ====
.PHONY: all lint clean

all:
	verilator --binary --timing --assert --top-module tb_icache -f vlog.f -o Vtb_icache
	./obj_dir/Vtb_icache | tee /dev/stderr | grep -q "TEST RESULT: PASS"

lint:
	verilator --lint-only --timing --top-module tb_icache -f vlog.f
	verilator --lint-only --top-module icache_top verilog/icache_pkg.sv verilog/icache_array.sv \
		verilog/icache.sv verilog/icache_refill.sv verilog/icache_top.sv

clean:
	rm -rf obj_dir
